/* src/alu_pkg.sv */
// Shared types and encodings of the execution cluster, compiled first and used by scoped name
package alu_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	// Default operand and result width, overridden from the top level
	localparam int data_w = 32;

	// ========================================================================
	// Descriptor and unit classes
	// ========================================================================

	// Functional unit class, taken from opc[3:1]
	typedef enum logic [2:0] {
		cls_none  = 3'd0,
		cls_bw    = 3'd1,
		cls_arith = 3'd2,
		cls_mul   = 3'd3
	} unit_e;

	// Micro-op descriptor as it arrives on each phase
	typedef struct packed {
		logic       n_en;
		logic [3:0] opc;
		logic       alt;
		logic       sel;
	} mo_desc_t;

	// Sub-op fields split out by the decoder
	typedef struct packed {
		logic lsb;
		logic alt;
		logic sel;
	} subop_t;

	// Bitwise unit, indexed by {lsb, alt}
	localparam logic [1:0] bw_and   = 2'b00;
	localparam logic [1:0] bw_or    = 2'b01;
	localparam logic [1:0] bw_xor   = 2'b10;
	localparam logic [1:0] bw_shift = 2'b11;

	// Arith unit, indexed by {lsb, alt}
	localparam logic [1:0] ar_add  = 2'b00;
	localparam logic [1:0] ar_sub  = 2'b01;
	localparam logic [1:0] ar_slt  = 2'b10;
	localparam logic [1:0] ar_sltu = 2'b11;

	// Multiply unit, indexed by lsb
	localparam logic mul_lo = 1'b0;
	localparam logic mul_hi = 1'b1;

endpackage

/* src/issue_if.sv */
// Decoder to unit issue bundle, driven through the issue modport and read through the unit modport
`timescale 1ns/100ps

interface issue_if #(
	parameter int DATA_W = alu_pkg::data_w
);

	// Per-phase sub-op fields
	alu_pkg::subop_t sop0;
	alu_pkg::subop_t sop1;

	// Per-phase operands, straight from the cluster inputs
	logic [DATA_W-1:0] a0;
	logic [DATA_W-1:0] b0;
	logic [DATA_W-1:0] a1;
	logic [DATA_W-1:0] b1;

	// Unit enables, bit 1 is phase 1 and bit 0 is phase 0
	logic [1:0] bw_en;
	logic [1:0] ar_en;
	logic [1:0] mul_en;

	// Decoder side
	modport issue (
		output sop0, sop1, a0, b0, a1, b1,
		output bw_en, ar_en, mul_en
	);

	// Unit side
	modport unit (
		input sop0, sop1, a0, b0, a1, b1,
		input bw_en, ar_en, mul_en
	);

endinterface

/* src/mo_decoder.sv */
// Combinational descriptor decoder, sorts both phases into per-unit enables on the issue bundle
`timescale 1ns/100ps

module mo_decoder #(
	parameter int DATA_W = alu_pkg::data_w
) (
	input  alu_pkg::mo_desc_t  mo0,
	input  logic               mo0_mask,
	input  logic [DATA_W-1:0]  src0a,
	input  logic [DATA_W-1:0]  src0b,
	input  alu_pkg::mo_desc_t  mo1,
	input  logic               mo1_mask,
	input  logic [DATA_W-1:0]  src1a,
	input  logic [DATA_W-1:0]  src1b,
	issue_if.issue             iss
);

	// Phase validity, n_en is active low and a set mask kills the op
	logic       vld0;
	logic       vld1;
	// Unit class of each phase
	logic [2:0] cls0;
	logic [2:0] cls1;

	assign vld0 = ~mo0.n_en & ~mo0_mask;
	assign vld1 = ~mo1.n_en & ~mo1_mask;

	assign cls0 = mo0.opc[3:1];
	assign cls1 = mo1.opc[3:1];

	// ========================================================================
	// Unit enables
	// ========================================================================

	// cls_none and unused codes match no unit and simply fall away
	assign iss.bw_en[0]  = vld0 && (cls0 == alu_pkg::cls_bw);
	assign iss.bw_en[1]  = vld1 && (cls1 == alu_pkg::cls_bw);
	assign iss.ar_en[0]  = vld0 && (cls0 == alu_pkg::cls_arith);
	assign iss.ar_en[1]  = vld1 && (cls1 == alu_pkg::cls_arith);
	assign iss.mul_en[0] = vld0 && (cls0 == alu_pkg::cls_mul);
	assign iss.mul_en[1] = vld1 && (cls1 == alu_pkg::cls_mul);

	// Sub-op fields, lsb is opcode bit 0
	assign iss.sop0 = {mo0.opc[0], mo0.alt, mo0.sel};
	assign iss.sop1 = {mo1.opc[0], mo1.alt, mo1.sel};

	// Operands pass through untouched
	assign iss.a0 = src0a;
	assign iss.b0 = src0b;
	assign iss.a1 = src1a;
	assign iss.b1 = src1b;

endmodule

/* src/alu_bw.sv */
// Bitwise and shift unit, captures one phase per cycle and drives its result in the next cycle
`timescale 1ns/100ps

module alu_bw #(
	parameter int DATA_W = alu_pkg::data_w
) (
	input  logic               clk,
	input  logic               rst,
	issue_if.unit              iss,
	output logic [1:0]         phase_en,
	output logic [DATA_W-1:0]  dout
);

	// Captured operands and sub-op
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	alu_pkg::subop_t   sop;
	// Execute-cycle valid and the phase it belongs to
	logic              ex_vld;
	logic              ex_ph1;
	// Shift helpers
	logic [4:0]        shamt_r;
	logic [DATA_W-1:0] res;

	// ========================================================================
	// Capture stage
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_vld <= 1'b0;
			ex_ph1 <= 1'b0;
		end else begin
			ex_vld <= |iss.bw_en;
			// Phase 1 wins when both phases land here
			ex_ph1 <= iss.bw_en[1];
		end
	end

	// Operands hold while idle
	always_ff @(posedge clk) begin
		if (|iss.bw_en) begin
			op_a <= iss.bw_en[1] ? iss.a1 : iss.a0;
			op_b <= iss.bw_en[1] ? iss.b1 : iss.b0;
			sop  <= iss.bw_en[1] ? iss.sop1 : iss.sop0;
		end
	end

	// ========================================================================
	// Execute stage
	// ========================================================================

	// Right shifts carry the negated amount in b[4:0]
	assign shamt_r = -op_b[4:0];

	always_comb begin
		case ({sop.lsb, sop.alt})
			alu_pkg::bw_and: res = op_a & op_b;
			alu_pkg::bw_or:  res = op_a | op_b;
			alu_pkg::bw_xor: res = op_a ^ op_b;
			default: begin
				// b[15] arithmetic, b[7] right
				case ({op_b[15], op_b[7]})
					2'b01:   res = op_a >> shamt_r;
					2'b11:   res = DATA_W'($signed(op_a) >>> shamt_r);
					// Arithmetic left is the same as logical left
					default: res = op_a << op_b[4:0];
				endcase
			end
		endcase
	end

	// sel low inverts the result
	assign dout = sop.sel ? res : ~res;

	assign phase_en = {ex_vld & ex_ph1, ex_vld & ~ex_ph1};

endmodule

/* src/alu_arith.sv */
// Add, subtract and set-less-than unit, one phase captured per cycle with a one-cycle result
`timescale 1ns/100ps

module alu_arith #(
	parameter int DATA_W = alu_pkg::data_w
) (
	input  logic               clk,
	input  logic               rst,
	issue_if.unit              iss,
	output logic [1:0]         phase_en,
	output logic [DATA_W-1:0]  dout
);

	// Captured operands, sel is reserved here so only {lsb, alt} is kept
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [1:0]        op;
	logic              ex_vld;
	logic              ex_ph1;
	// Compare results
	logic              lt_s;
	logic              lt_u;

	// ========================================================================
	// Capture stage
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_vld <= 1'b0;
			ex_ph1 <= 1'b0;
		end else begin
			ex_vld <= |iss.ar_en;
			ex_ph1 <= iss.ar_en[1];
		end
	end

	// Phase 1 has priority, operands hold while idle
	always_ff @(posedge clk) begin
		if (|iss.ar_en) begin
			op_a <= iss.ar_en[1] ? iss.a1 : iss.a0;
			op_b <= iss.ar_en[1] ? iss.b1 : iss.b0;
			op   <= iss.ar_en[1] ? {iss.sop1.lsb, iss.sop1.alt} : {iss.sop0.lsb, iss.sop0.alt};
		end
	end

	// ========================================================================
	// Execute stage
	// ========================================================================

	assign lt_s = $signed(op_a) < $signed(op_b);
	assign lt_u = op_a < op_b;

	always_comb begin
		case (op)
			alu_pkg::ar_add: dout = op_a + op_b;
			alu_pkg::ar_sub: dout = op_a - op_b;
			// Compares return 0 or 1, zero extended
			alu_pkg::ar_slt: dout = {{(DATA_W-1){1'b0}}, lt_s};
			default:         dout = {{(DATA_W-1){1'b0}}, lt_u};
		endcase
	end

	assign phase_en = {ex_vld & ex_ph1, ex_vld & ~ex_ph1};

endmodule

/* src/alu_mul.sv */
// Multiply unit, returns the low or signed high word of the product one cycle after capture
`timescale 1ns/100ps

module alu_mul #(
	parameter int DATA_W = alu_pkg::data_w
) (
	input  logic               clk,
	input  logic               rst,
	issue_if.unit              iss,
	output logic [1:0]         phase_en,
	output logic [DATA_W-1:0]  dout
);

	logic [DATA_W-1:0]   op_a;
	logic [DATA_W-1:0]   op_b;
	// Only opcode bit 0 matters to this unit
	logic                op_hi;
	logic                ex_vld;
	logic                ex_ph1;
	logic [2*DATA_W-1:0] prod;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_vld <= 1'b0;
			ex_ph1 <= 1'b0;
		end else begin
			ex_vld <= |iss.mul_en;
			ex_ph1 <= iss.mul_en[1];
		end
	end

	// Same phase-1 priority capture as the other units
	always_ff @(posedge clk) begin
		if (|iss.mul_en) begin
			op_a  <= iss.mul_en[1] ? iss.a1 : iss.a0;
			op_b  <= iss.mul_en[1] ? iss.b1 : iss.b0;
			op_hi <= iss.mul_en[1] ? iss.sop1.lsb : iss.sop0.lsb;
		end
	end

	// One signed multiplier
	// low word is identical for signed and unsigned operands
	assign prod = $signed(op_a) * $signed(op_b);

	assign dout = (op_hi == alu_pkg::mul_hi) ? prod[2*DATA_W-1:DATA_W] : prod[DATA_W-1:0];

	assign phase_en = {ex_vld & ex_ph1, ex_vld & ~ex_ph1};

endmodule

/* src/wb_merge.sv */
// Writeback merge, picks one unit result per phase, registers it and adds the zero flag
`timescale 1ns/100ps

module wb_merge #(
	parameter int DATA_W = alu_pkg::data_w
) (
	input  logic               clk,
	input  logic               rst,
	input  logic [1:0]         bw_phase_en,
	input  logic [DATA_W-1:0]  bw_dout,
	input  logic [1:0]         ar_phase_en,
	input  logic [DATA_W-1:0]  ar_dout,
	input  logic [1:0]         mul_phase_en,
	input  logic [DATA_W-1:0]  mul_dout,
	output logic               wb0_valid,
	output logic [DATA_W-1:0]  wb0_data,
	output logic               wb0_zero,
	output logic               wb1_valid,
	output logic [DATA_W-1:0]  wb1_data,
	output logic               wb1_zero
);

	// Per-phase claim and selected result
	logic [1:0]        claim;
	logic [DATA_W-1:0] sel_data [2];
	// Writeback registers, index is the phase
	logic [1:0]        wb_valid_q;
	logic [DATA_W-1:0] wb_data_q [2];
	logic [1:0]        wb_zero_q;

	assign claim = bw_phase_en | ar_phase_en | mul_phase_en;

	// Fixed order bw, arith, mul
	// idle phases carry zero data
	always_comb begin
		for (int p = 0; p < 2; p++) begin
			if (bw_phase_en[p])
				sel_data[p] = bw_dout;
			else if (ar_phase_en[p])
				sel_data[p] = ar_dout;
			else if (mul_phase_en[p])
				sel_data[p] = mul_dout;
			else
				sel_data[p] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid_q <= '0;
			wb_zero_q  <= '0;
			wb_data_q  <= '{default: '0};
		end else begin
			for (int p = 0; p < 2; p++) begin
				wb_valid_q[p] <= claim[p];
				wb_data_q[p]  <= sel_data[p];
				// Zero flag from the selected data, ahead of the register
				wb_zero_q[p]  <= claim[p] & ~|sel_data[p];
			end
		end
	end

	assign wb0_valid = wb_valid_q[0];
	assign wb0_data  = wb_data_q[0];
	assign wb0_zero  = wb_zero_q[0];
	assign wb1_valid = wb_valid_q[1];
	assign wb1_data  = wb_data_q[1];
	assign wb1_zero  = wb_zero_q[1];

endmodule

/* src/alu_cluster.sv */
// Execution cluster top, two micro-ops in per cycle and two writeback ports out two cycles later
`timescale 1ns/100ps

module alu_cluster #(
	parameter int DATA_W = alu_pkg::data_w
) (
	input  logic               clk,
	input  logic               rst,
	// Phase 0 issue
	input  alu_pkg::mo_desc_t  mo0,
	input  logic               mo0_mask,
	input  logic [DATA_W-1:0]  src0a,
	input  logic [DATA_W-1:0]  src0b,
	// Phase 1 issue
	input  alu_pkg::mo_desc_t  mo1,
	input  logic               mo1_mask,
	input  logic [DATA_W-1:0]  src1a,
	input  logic [DATA_W-1:0]  src1b,
	// Writeback ports
	output logic               wb0_valid,
	output logic [DATA_W-1:0]  wb0_data,
	output logic               wb0_zero,
	output logic               wb1_valid,
	output logic [DATA_W-1:0]  wb1_data,
	output logic               wb1_zero
);

	// Unit result paths
	logic [1:0]        bw_phase_en;
	logic [DATA_W-1:0] bw_dout;
	logic [1:0]        ar_phase_en;
	logic [DATA_W-1:0] ar_dout;
	logic [1:0]        mul_phase_en;
	logic [DATA_W-1:0] mul_dout;

	issue_if #(.DATA_W(DATA_W)) iss ();

	// ========================================================================
	// Decode, three peer units, writeback merge
	// ========================================================================

	mo_decoder #(.DATA_W(DATA_W)) i_mo_decoder (
		.mo0      (mo0),
		.mo0_mask (mo0_mask),
		.src0a    (src0a),
		.src0b    (src0b),
		.mo1      (mo1),
		.mo1_mask (mo1_mask),
		.src1a    (src1a),
		.src1b    (src1b),
		.iss      (iss.issue)
	);

	alu_bw #(.DATA_W(DATA_W)) i_alu_bw (
		.clk      (clk),
		.rst      (rst),
		.iss      (iss.unit),
		.phase_en (bw_phase_en),
		.dout     (bw_dout)
	);

	alu_arith #(.DATA_W(DATA_W)) i_alu_arith (
		.clk      (clk),
		.rst      (rst),
		.iss      (iss.unit),
		.phase_en (ar_phase_en),
		.dout     (ar_dout)
	);

	alu_mul #(.DATA_W(DATA_W)) i_alu_mul (
		.clk      (clk),
		.rst      (rst),
		.iss      (iss.unit),
		.phase_en (mul_phase_en),
		.dout     (mul_dout)
	);

	wb_merge #(.DATA_W(DATA_W)) i_wb_merge (
		.clk          (clk),
		.rst          (rst),
		.bw_phase_en  (bw_phase_en),
		.bw_dout      (bw_dout),
		.ar_phase_en  (ar_phase_en),
		.ar_dout      (ar_dout),
		.mul_phase_en (mul_phase_en),
		.mul_dout     (mul_dout),
		.wb0_valid    (wb0_valid),
		.wb0_data     (wb0_data),
		.wb0_zero     (wb0_zero),
		.wb1_valid    (wb1_valid),
		.wb1_data     (wb1_data),
		.wb1_zero     (wb1_zero)
	);

endmodule

/* bench/alu_cluster_sva.sv */
// Writeback assertions for the merge stage, attached to every wb_merge instance by bind
`timescale 1ns/100ps

module alu_cluster_sva #(
	parameter int DATA_W = alu_pkg::data_w
) (
	input logic              clk,
	input logic              rst,
	input logic [1:0]        bw_phase_en,
	input logic [1:0]        ar_phase_en,
	input logic [1:0]        mul_phase_en,
	input logic              wb0_valid,
	input logic [DATA_W-1:0] wb0_data,
	input logic              wb0_zero,
	input logic              wb1_valid,
	input logic [DATA_W-1:0] wb1_data,
	input logic              wb1_zero
);

	// One op per phase, so at most one unit may claim it
	a_one_claim: assert property (@(posedge clk) disable iff (rst)
		$onehot0({bw_phase_en[0], ar_phase_en[0], mul_phase_en[0]}) &&
		$onehot0({bw_phase_en[1], ar_phase_en[1], mul_phase_en[1]}))
		else $error("Two units claimed the same writeback phase");

	// Writeback stays idle while reset is applied
	a_rst_idle: assert property (@(posedge clk) rst |=> !wb0_valid && !wb1_valid)
		else $error("Writeback valid seen after a reset edge");

	// Zero flag tracks the data of a valid writeback
	a_zero0: assert property (@(posedge clk) disable iff (rst)
		wb0_valid |-> (wb0_zero == (wb0_data == '0)))
		else $error("Phase 0 zero flag does not match its data");
	a_zero1: assert property (@(posedge clk) disable iff (rst)
		wb1_valid |-> (wb1_zero == (wb1_data == '0)))
		else $error("Phase 1 zero flag does not match its data");

endmodule

bind wb_merge alu_cluster_sva #(.DATA_W(DATA_W)) i_alu_cluster_sva (
	.clk          (clk),
	.rst          (rst),
	.bw_phase_en  (bw_phase_en),
	.ar_phase_en  (ar_phase_en),
	.mul_phase_en (mul_phase_en),
	.wb0_valid    (wb0_valid),
	.wb0_data     (wb0_data),
	.wb0_zero     (wb0_zero),
	.wb1_valid    (wb1_valid),
	.wb1_data     (wb1_data),
	.wb1_zero     (wb1_zero)
);

/* bench/tb_alu_cluster.sv */
// Self-checking testbench that runs directed and random traffic through the cluster against a model
`timescale 1ns/100ps

module tb_alu_cluster;

	localparam int data_w      = alu_pkg::data_w;
	localparam int rst_cycles  = 16;
	// Upper bound on the directed section
	localparam int dir_cycles  = 80;
	localparam int rand_cycles = 2000;
	localparam int tail_cycles = 4;
	localparam int timeout_ns  = (rst_cycles + dir_cycles + rand_cycles + tail_cycles + 20) * 10;

	// Descriptor with only n_en set
	localparam alu_pkg::mo_desc_t idle_desc = 7'b100_0000;

	// Expected writeback of one input pair
	typedef struct packed {
		logic              v0;
		logic [data_w-1:0] d0;
		logic              v1;
		logic [data_w-1:0] d1;
	} exp_t;

	logic              clk;
	logic              rst;
	alu_pkg::mo_desc_t mo0;
	logic              mo0_mask;
	logic [data_w-1:0] src0a;
	logic [data_w-1:0] src0b;
	alu_pkg::mo_desc_t mo1;
	logic              mo1_mask;
	logic [data_w-1:0] src1a;
	logic [data_w-1:0] src1b;
	logic              wb0_valid;
	logic [data_w-1:0] wb0_data;
	logic              wb0_zero;
	logic              wb1_valid;
	logic [data_w-1:0] wb1_data;
	logic              wb1_zero;

	int   errors    = 0;
	int   checks    = 0;
	int   rand_seed = 11514;
	// Two-deep expectation delay line
	exp_t pipe1;
	exp_t pipe2;
	logic started;

	// Arith cases with add and sub wrap and compares where signed and unsigned disagree
	logic [data_w-1:0] ar_a [8] = '{32'h7fff_ffff, 32'hffff_ffff, 32'h0, 32'h8000_0000,
		32'hffff_ffff, 32'hffff_ffff, 32'h1, 32'h1};
	logic [data_w-1:0] ar_b [8] = '{32'h1, 32'h1, 32'h1, 32'h1,
		32'h1, 32'h1, 32'h8000_0000, 32'h8000_0000};
	logic [1:0]        ar_op [8] = '{2'd0, 2'd0, 2'd1, 2'd1, 2'd2, 2'd3, 2'd2, 2'd3};
	// Multiply cases with mixed signs, both negative, both positive and the most negative value
	logic [data_w-1:0] mul_a [4] = '{32'hffff_fffd, 32'hffff_fffb, 32'h7fff_ffff, 32'h8000_0000};
	logic [data_w-1:0] mul_b [4] = '{32'h7, 32'hffff_fff7, 32'h7fff_ffff, 32'h2};

	alu_cluster #(.DATA_W(data_w)) i_alu_cluster (
		.clk       (clk),
		.rst       (rst),
		.mo0       (mo0),
		.mo0_mask  (mo0_mask),
		.src0a     (src0a),
		.src0b     (src0b),
		.mo1       (mo1),
		.mo1_mask  (mo1_mask),
		.src1a     (src1a),
		.src1b     (src1b),
		.wb0_valid (wb0_valid),
		.wb0_data  (wb0_data),
		.wb0_zero  (wb0_zero),
		.wb1_valid (wb1_valid),
		.wb1_data  (wb1_data),
		.wb1_zero  (wb1_zero)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ========================================================================
	// Reference model
	// ========================================================================

	// Result of one op by unit class
	function automatic logic [data_w-1:0] exec_op(logic [2:0] cls, logic lsb, logic alt,
		logic sel, logic [data_w-1:0] a, logic [data_w-1:0] b);
		logic [data_w-1:0]   r;
		logic [4:0]          amt;
		logic [2*data_w-1:0] pu;
		logic [2*data_w-1:0] ps;
		r = '0;
		case (cls)
			3'd1: begin
				case ({lsb, alt})
					2'b00: r = a & b;
					2'b01: r = a | b;
					2'b10: r = a ^ b;
					default: begin
						// Right shifts encode the negated amount
						amt = b[7] ? 5'd0 - b[4:0] : b[4:0];
						if (!b[7])
							r = a << amt;
						else if (b[15])
							r = data_w'($signed(a) >>> amt);
						else
							r = a >> amt;
					end
				endcase
				if (!sel)
					r = ~r;
			end
			3'd2: begin
				case ({lsb, alt})
					2'b00: r = a + b;
					2'b01: r = a - b;
					2'b10: r = data_w'($signed(a) < $signed(b));
					default: r = data_w'(a < b);
				endcase
			end
			3'd3: begin
				pu = {{data_w{1'b0}}, a} * {{data_w{1'b0}}, b};
				ps = $signed({{data_w{a[data_w-1]}}, a}) * $signed({{data_w{b[data_w-1]}}, b});
				r = lsb ? ps[2*data_w-1:data_w] : pu[data_w-1:0];
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	// Expected writeback pair where masked, disabled and unknown-class ops fall away
	function automatic exp_t ref_model(alu_pkg::mo_desc_t m0, logic k0, logic [data_w-1:0] a0,
		logic [data_w-1:0] b0, alu_pkg::mo_desc_t m1, logic k1, logic [data_w-1:0] a1,
		logic [data_w-1:0] b1);
		exp_t e;
		e.v0 = !m0.n_en && !k0 && (m0.opc[3:1] >= 3'd1) && (m0.opc[3:1] <= 3'd3);
		e.v1 = !m1.n_en && !k1 && (m1.opc[3:1] >= 3'd1) && (m1.opc[3:1] <= 3'd3);
		// Phase 1 wins when both phases target the same unit
		if (e.v0 && e.v1 && (m0.opc[3:1] == m1.opc[3:1]))
			e.v0 = 1'b0;
		e.d0 = e.v0 ? exec_op(m0.opc[3:1], m0.opc[0], m0.alt, m0.sel, a0, b0) : '0;
		e.d1 = e.v1 ? exec_op(m1.opc[3:1], m1.opc[0], m1.alt, m1.sel, a1, b1) : '0;
		return e;
	endfunction

	task automatic check_value(input string name, input logic [data_w-1:0] got,
		input logic [data_w-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// Values read at the edge were registered in the previous cycle
	initial begin
		pipe1   = '0;
		pipe2   = '0;
		started = 1'b0;
		forever begin
			@(posedge clk);
			if (started) begin
				check_value("wb0_valid", wb0_valid, pipe2.v0);
				check_value("wb0_data", wb0_data, pipe2.d0);
				check_value("wb0_zero", wb0_zero, pipe2.v0 && (pipe2.d0 == '0));
				check_value("wb1_valid", wb1_valid, pipe2.v1);
				check_value("wb1_data", wb1_data, pipe2.d1);
				check_value("wb1_zero", wb1_zero, pipe2.v1 && (pipe2.d1 == '0));
			end
			started = 1'b1;
			// Reset clears the units and the merge registers alike
			if (rst) begin
				pipe2 = '0;
				pipe1 = '0;
			end else begin
				pipe2 = pipe1;
				pipe1 = ref_model(mo0, mo0_mask, src0a, src0b, mo1, mo1_mask, src1a, src1b);
			end
		end
	end

	// ========================================================================
	// Stimulus helpers
	// ========================================================================

	function automatic alu_pkg::mo_desc_t make_desc(logic n_en, logic [2:0] cls, logic lsb,
		logic alt, logic sel);
		return {n_en, cls, lsb, alt, sel};
	endfunction

	// Shift control in b with noise in the upper bits
	function automatic logic [data_w-1:0] shift_b(logic arith, logic right, int amt);
		logic [data_w-1:0] b;
		b       = 32'hc3a5_0000;
		b[15]   = arith;
		b[7]    = right;
		b[4:0]  = right ? 5'(32 - amt) : 5'(amt);
		return b;
	endfunction

	task automatic drive_pair(input alu_pkg::mo_desc_t d0, input logic k0,
		input logic [data_w-1:0] a0, input logic [data_w-1:0] b0,
		input alu_pkg::mo_desc_t d1, input logic k1,
		input logic [data_w-1:0] a1, input logic [data_w-1:0] b1);
		@(negedge clk);
		mo0      = d0;
		mo0_mask = k0;
		src0a    = a0;
		src0b    = b0;
		mo1      = d1;
		mo1_mask = k1;
		src1a    = a1;
		src1b    = b1;
	endtask

	// One op on the chosen phase while the other phase idles
	task automatic drive_one(input int ph, input alu_pkg::mo_desc_t d,
		input logic [data_w-1:0] a, input logic [data_w-1:0] b);
		if (ph == 1)
			drive_pair(idle_desc, 1'b0, '0, '0, d, 1'b0, a, b);
		else
			drive_pair(d, 1'b0, a, b, idle_desc, 1'b0, '0, '0);
	endtask

	function automatic alu_pkg::mo_desc_t rand_desc();
		logic [2:0] c;
		c = 3'($urandom_range(0, 4));
		// Occasionally an unused class code
		if (c == 3'd4)
			c = 3'($urandom_range(4, 7));
		return make_desc($urandom_range(0, 7) == 0, c, 1'($urandom), 1'($urandom), 1'($urandom));
	endfunction

	// Small operands now and then make zero results show up
	function automatic logic [data_w-1:0] rand_operand();
		if ($urandom_range(0, 3) == 0)
			return data_w'($urandom_range(0, 3));
		return data_w'($urandom);
	endfunction

	// ========================================================================
	// Test sections
	// ========================================================================

	task automatic run_bitwise();
		int amts [3] = '{0, 1, 31};
		for (int ph = 0; ph < 2; ph++) begin
			// All four ops with and without inversion
			for (int code = 0; code < 4; code++) begin
				for (int s = 0; s < 2; s++)
					drive_one(ph, make_desc(1'b0, 3'd1, code[1], code[0], s[0]),
						32'hf0f0_3c3c, 32'h0ff0_a5a5);
			end
			// Disjoint AND gives zero
			drive_one(ph, make_desc(1'b0, 3'd1, 1'b0, 1'b0, 1'b1), 32'hffff_0000, 32'h0000_ffff);
			// Left, right, arithmetic left, arithmetic right
			for (int m = 0; m < 4; m++) begin
				for (int k = 0; k < 3; k++)
					drive_one(ph, make_desc(1'b0, 3'd1, 1'b1, 1'b1, 1'b1), 32'h8421_f00f,
						shift_b(m[1], m[0], amts[k]));
			end
		end
	endtask

	task automatic run_arith_mul();
		for (int i = 0; i < 8; i++)
			drive_pair(make_desc(1'b0, 3'd2, ar_op[i][1], ar_op[i][0], 1'b1), 1'b0, ar_a[i], ar_b[i],
				make_desc(1'b0, 3'd3, i[0], 1'b0, 1'b0), 1'b0, mul_a[i/2], mul_b[i/2]);
		// Same cases with the phases swapped
		for (int i = 0; i < 8; i++)
			drive_pair(make_desc(1'b0, 3'd3, i[0], 1'b0, 1'b0), 1'b0, mul_a[i/2], mul_b[i/2],
				make_desc(1'b0, 3'd2, ar_op[i][1], ar_op[i][0], 1'b0), 1'b0, ar_a[i], ar_b[i]);
	endtask

	task automatic run_collisions();
		for (int c = 1; c < 4; c++)
			drive_pair(make_desc(1'b0, 3'(c), 1'b0, 1'b1, 1'b1), 1'b0, 32'h1234_5678, 32'h9,
				make_desc(1'b0, 3'(c), 1'b1, 1'b0, 1'b1), 1'b0, 32'hdead_beef, 32'h3);
		// Masked phase 0 and disabled phase 1 give no output
		drive_pair(make_desc(1'b0, 3'd1, 1'b0, 1'b1, 1'b1), 1'b1, 32'h5, 32'h6,
			make_desc(1'b1, 3'd2, 1'b0, 1'b0, 1'b0), 1'b0, 32'h7, 32'h8);
		// Masked phase 1 leaves the unit to phase 0
		drive_pair(make_desc(1'b0, 3'd2, 1'b0, 1'b0, 1'b1), 1'b0, 32'h5, 32'h6,
			make_desc(1'b0, 3'd2, 1'b0, 1'b1, 1'b1), 1'b1, 32'h7, 32'h8);
		drive_pair(make_desc(1'b0, 3'd3, 1'b0, 1'b0, 1'b0), 1'b0, 32'h3, 32'h4,
			make_desc(1'b1, 3'd3, 1'b1, 1'b0, 1'b0), 1'b0, 32'h5, 32'h6);
		// No unit class on either phase
		drive_pair(make_desc(1'b0, 3'd0, 1'b1, 1'b1, 1'b1), 1'b0, 32'h1, 32'h2,
			make_desc(1'b0, 3'd5, 1'b0, 1'b0, 1'b1), 1'b0, 32'h3, 32'h4);
	endtask

	task automatic run_random();
		for (int i = 0; i < rand_cycles; i++) begin
			drive_pair(rand_desc(), $urandom_range(0, 7) == 0, rand_operand(), rand_operand(),
				rand_desc(), $urandom_range(0, 7) == 0, rand_operand(), rand_operand());
			// Reset in the middle of traffic
			if (i == 1000)
				rst = 1'b1;
			if (i == 1003)
				rst = 1'b0;
		end
	endtask

	// ========================================================================
	// Main sequence and watchdog
	// ========================================================================

	initial begin
		void'($urandom(rand_seed));
		rst      = 1'b1;
		mo0      = idle_desc;
		mo0_mask = 1'b0;
		src0a    = '0;
		src0b    = '0;
		mo1      = idle_desc;
		mo1_mask = 1'b0;
		src1a    = '0;
		src1b    = '0;
		repeat (rst_cycles) @(negedge clk);
		rst = 1'b0;
		run_bitwise();
		run_arith_mul();
		run_collisions();
		run_random();
		// Drain the two-stage pipe
		repeat (tail_cycles) drive_pair(idle_desc, 1'b0, '0, '0, idle_desc, 1'b0, '0, '0);
		@(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("Timeout: the run did not finish within %0d ns", timeout_ns);
		$display("Verification failed");
		$finish;
	end

endmodule

/* flist.f */
src/alu_pkg.sv
src/issue_if.sv
src/mo_decoder.sv
src/alu_bw.sv
src/alu_arith.sv
src/alu_mul.sv
src/wb_merge.sv
src/alu_cluster.sv
bench/alu_cluster_sva.sv
bench/tb_alu_cluster.sv

/* run.sh */
#!/bin/sh
# Builds the execution cluster testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps \
	--top-module tb_alu_cluster -f flist.f \
	--Mdir obj_dir -o tb_alu_cluster
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_alu_cluster 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Verification passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
